/* rv32i_decoder.f */
logic/rv32i_pkg.sv
logic/rv32i_dec_if.sv
logic/imm_gen.sv
logic/alu_op_decoder.sv
logic/major_decoder.sv
logic/dec_handshake.sv
logic/rv32i_decoder.sv
verif/rv32i_decoder_sva.sv
verif/tb_rv32i_decoder.sv

/* Bender.yml */
package:
  name: rv32i_decoder

sources:
  - logic/rv32i_pkg.sv
  - logic/rv32i_dec_if.sv
  - logic/imm_gen.sv
  - logic/alu_op_decoder.sv
  - logic/major_decoder.sv
  - logic/dec_handshake.sv
  - logic/rv32i_decoder.sv
  - target: test
    files:
      - verif/rv32i_decoder_sva.sv
      - verif/tb_rv32i_decoder.sv

/* verif/tb_rv32i_decoder.sv */
module tb_rv32i_decoder import rv32i_pkg::*; ();

    localparam int XLEN        = XLEN_DEFAULT;
    localparam int N_TRANSFERS = 2000;
    localparam int CYCLE_LIMIT = N_TRANSFERS * 6 + 16 + 1000;

    localparam int MODE_ALU     = 0;
    localparam int MODE_CTRL    = 1;
    localparam int MODE_ALL     = 2;
    localparam int MODE_ILLEGAL = 3;
    localparam int MODE_MIX     = 4;

    typedef struct packed {
        logic            err;
        logic            jump;
        zone_t           zone;
        logic            regd_tgt;
        logic            regs1_rd;
        logic            regs2_rd;
        logic            link;
        logic            sels1_pc;
        logic            sels2_imm;
        logic            selcmps2_imm;
        logic            conditional;
        alu_op_t         aluop;
        logic [XLEN-1:0] imm;
    } expect_t;

    logic            clk_i;
    logic            arst_n_i;
    logic            req_i;
    ins_t            ins_i;
    logic            ack_o;
    logic            ins_err_o;
    logic            jump_o;
    zone_t           zone_o;
    logic            regd_tgt_o;
    reg_addr_t       regd_addr_o;
    logic            regs1_rd_o;
    reg_addr_t       regs1_addr_o;
    logic            regs2_rd_o;
    reg_addr_t       regs2_addr_o;
    logic [XLEN-1:0] imm_o;
    logic            link_o;
    logic            sels1_pc_o;
    logic            sels2_imm_o;
    logic            selcmps2_imm_o;
    alu_op_t         aluop_o;
    funct3_t         funct3_o;
    logic            conditional_o;

    integer seed;
    int     n_errors;
    int     n_checks;
    int     n_tests;
    int     cycles;
    string  test_name;

    rv32i_decoder #(.XLEN(XLEN)) dut_i (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // watchdog
    initial begin
        cycles = 0;
        while (cycles <= CYCLE_LIMIT) begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout after %0d cycles, the handshake stalled", cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    // ------------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------------
    function automatic opcode_t kept_opcode(input int idx);
        case (idx)
            0: return OPC_JAL;
            1: return OPC_JALR;
            2: return OPC_BRANCH;
            3: return OPC_LOAD;
            4: return OPC_STORE;
            5: return OPC_LUI;
            6: return OPC_AUIPC;
            7: return OPC_OPIMM;
            default: return OPC_OP;
        endcase
    endfunction

    function automatic logic is_kept(input opcode_t opc);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < 9; i++) begin
            if (kept_opcode(i) == opc) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    function automatic expect_t ref_decode(input ins_t w);
        expect_t    e;
        logic [7:0] ctl; // jump, rd, rs1, rs2, link, pc, imm, cond
        funct3_t    f3;
        funct7_t    f7;
        logic       is_op;
        e     = '0;
        ctl   = '0;
        f3    = w[14:12];
        f7    = w[31:25];
        is_op = (w[6:0] == OPC_OP);
        case (w[6:0])
            OPC_LUI: begin
                ctl     = 8'b0100_0010;
                e.zone  = REGFILE;
                e.aluop = MOV;
                e.imm   = {w[31:12], 12'b0};
            end
            OPC_AUIPC: begin
                ctl    = 8'b0100_0110;
                e.zone = REGFILE;
                e.imm  = {w[31:12], 12'b0};
            end
            OPC_JAL: begin
                ctl    = 8'b1100_1110;
                e.zone = REGFILE;
                e.imm  = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            OPC_JALR: begin
                ctl    = 8'b1110_1010;
                e.zone = REGFILE;
                e.err  = (f3 != 3'd0);
                e.imm  = {{20{w[31]}}, w[31:20]};
            end
            OPC_BRANCH: begin
                ctl   = 8'b1011_0111;
                e.err = (f3 == 3'd2 || f3 == 3'd3);
                e.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            OPC_LOAD: begin
                ctl    = 8'b0110_0010;
                e.zone = LOADQ;
                e.err  = (f3 == 3'd3 || f3 >= 3'd6);
                e.imm  = {{20{w[31]}}, w[31:20]};
            end
            OPC_STORE: begin
                ctl    = 8'b0011_0010;
                e.zone = STOREQ;
                e.err  = (f3 >= 3'd3);
                e.imm  = {{20{w[31]}}, w[31:25], w[11:7]};
            end
            OPC_OPIMM: begin
                ctl    = 8'b0110_0010;
                e.zone = REGFILE;
                e.imm  = {{20{w[31]}}, w[31:20]};
            end
            OPC_OP: begin
                ctl    = 8'b0111_0000;
                e.zone = REGFILE;
            end
            default: begin
                e.err = 1'b1;
            end
        endcase
        {e.jump, e.regd_tgt, e.regs1_rd, e.regs2_rd,
         e.link, e.sels1_pc, e.sels2_imm, e.conditional} = ctl;

        if (w[6:0] == OPC_OP || w[6:0] == OPC_OPIMM) begin
            case (f3)
                3'd0: begin
                    if (is_op && f7 == FUNCT7_ALT) begin
                        e.aluop = SUB;
                    end
                    e.err = is_op && f7 != FUNCT7_BASE && f7 != FUNCT7_ALT;
                end
                3'd1: begin
                    e.aluop = SLL;
                    e.err   = (f7 != FUNCT7_BASE); // shamt[5] set too
                end
                3'd2, 3'd3: begin
                    e.aluop        = (f3 == 3'd2) ? SLT : SLTU;
                    e.selcmps2_imm = !is_op;
                    e.err          = is_op && f7 != FUNCT7_BASE;
                end
                3'd5: begin
                    if (f7 == FUNCT7_BASE) begin
                        e.aluop = SRL;
                    end else if (f7 == FUNCT7_ALT) begin
                        e.aluop = SRA;
                    end else begin
                        e.err = 1'b1;
                    end
                end
                default: begin
                    e.aluop = (f3 == 3'd4) ? XOR : (f3 == 3'd6) ? OR : AND;
                    e.err   = is_op && f7 != FUNCT7_BASE;
                end
            endcase
        end
        return e;
    endfunction

    // ------------------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------------------
    task automatic check_flag(input string field, input logic exp, input logic act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("MISMATCH %s %s: expected %0b, actual %0b", test_name, field, exp, act);
        end
    endtask

    task automatic check_zone(input string field, input zone_t exp, input zone_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("MISMATCH %s %s: expected %s, actual %s", test_name, field,
                     exp.name(), act.name());
        end
    endtask

    task automatic check_aluop(input string field, input alu_op_t exp, input alu_op_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("MISMATCH %s %s: expected %s, actual %s", test_name, field,
                     exp.name(), act.name());
        end
    endtask

    task automatic check_addr(input string field, input reg_addr_t exp, input reg_addr_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("MISMATCH %s %s: expected %0d, actual %0d", test_name, field, exp, act);
        end
    endtask

    task automatic check_funct3(input string field, input funct3_t exp, input funct3_t act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("MISMATCH %s %s: expected %0d, actual %0d", test_name, field, exp, act);
        end
    endtask

    task automatic check_imm(input string field, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
        n_checks++;
        if (exp !== act) begin
            n_errors++;
            $display("MISMATCH %s %s: expected %h, actual %h", test_name, field, exp, act);
        end
    endtask

    task automatic check_outputs(input expect_t e, input ins_t w);
        check_flag("ins_err", e.err, ins_err_o);
        check_flag("jump", e.jump, jump_o);
        check_zone("zone", e.zone, zone_o);
        check_flag("regd_tgt", e.regd_tgt, regd_tgt_o);
        check_flag("regs1_rd", e.regs1_rd, regs1_rd_o);
        check_flag("regs2_rd", e.regs2_rd, regs2_rd_o);
        check_flag("link", e.link, link_o);
        check_flag("sels1_pc", e.sels1_pc, sels1_pc_o);
        check_flag("sels2_imm", e.sels2_imm, sels2_imm_o);
        check_flag("selcmps2_imm", e.selcmps2_imm, selcmps2_imm_o);
        check_flag("conditional", e.conditional, conditional_o);
        check_aluop("aluop", e.aluop, aluop_o);
        check_imm("imm", e.imm, imm_o);
        check_addr("regd_addr", w[11:7], regd_addr_o);
        check_addr("regs1_addr", w[19:15], regs1_addr_o);
        check_addr("regs2_addr", w[24:20], regs2_addr_o);
        check_funct3("funct3", w[14:12], funct3_o);
    endtask

    // ------------------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------------------
    task automatic gen_word(input int mode, output ins_t word);
        int      pick;
        opcode_t opc;
        word = $random(seed);
        pick = $unsigned($random(seed)) % 100;
        if (pick < 40) begin
            word[31:25] = FUNCT7_BASE;
        end else if (pick < 70) begin
            word[31:25] = FUNCT7_ALT;
        end
        pick = $unsigned($random(seed)) % 100;
        case (mode)
            MODE_ALU:  opc = kept_opcode(7 + pick % 2);
            MODE_CTRL: opc = kept_opcode(pick % 5);
            MODE_ALL:  opc = kept_opcode(pick % 9);
            MODE_ILLEGAL: begin
                if (pick < 25) begin
                    opc = 7'b1110011; // system
                end else if (pick < 50) begin
                    opc = 7'b0001111; // misc-mem
                end else begin
                    opc = word[6:0];
                    while (is_kept(opc)) begin
                        opc = opc + 7'd1;
                    end
                end
            end
            default: opc = (pick < 85) ? kept_opcode(pick % 9) : word[6:0];
        endcase
        word[6:0] = opc;
    endtask

    // one four-phase transfer, entered and left on a falling edge
    task automatic run_transfer(input ins_t word);
        expect_t e;
        int      lat;
        int      hold;
        e     = ref_decode(word);
        req_i = 1'b1;
        ins_i = word;
        lat   = 0;
        while (!ack_o && lat < 8) begin
            @(negedge clk_i);
            lat++;
        end
        if (!ack_o) begin
            n_errors++;
            $display("%s: ack_o did not rise within 8 cycles for word %h", test_name, word);
            req_i = 1'b0;
            return;
        end
        if (lat != 2) begin
            n_errors++;
            $display("MISMATCH %s ack_latency: expected 2, actual %0d", test_name, lat);
        end
        check_outputs(e, word);
        hold = $unsigned($random(seed)) % 3;
        repeat (hold) begin
            @(negedge clk_i);
            check_flag("ack_hold", 1'b1, ack_o);
            check_outputs(e, word);
        end
        req_i = 1'b0;
        ins_i = $random(seed); // source is free to change the word now
        @(negedge clk_i);
        check_flag("ack_release", 1'b0, ack_o);
        check_outputs(e, word);
    endtask

    task automatic run_test(input string name, input int mode, input int count);
        int   start_errors;
        ins_t word;
        test_name    = name;
        start_errors = n_errors;
        for (int i = 0; i < count; i++) begin
            gen_word(mode, word);
            run_transfer(word);
        end
        n_tests++;
        $display("test %-16s transfers=%0d errors=%0d", name, count, n_errors - start_errors);
    endtask

    task automatic reset_test();
        int start_errors;
        test_name    = "reset_state";
        start_errors = n_errors;
        check_flag("ack", 1'b0, ack_o);
        check_outputs('0, '0);
        n_tests++;
        $display("test %-16s errors=%0d", test_name, n_errors - start_errors);
    endtask

    initial begin
        seed     = 32'h574d;
        n_errors = 0;
        n_checks = 0;
        n_tests  = 0;
        arst_n_i = 1'b0;
        req_i    = 1'b0;
        ins_i    = '0;
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;

        reset_test();
        run_test("alu_decode", MODE_ALU, 400);
        run_test("immediates", MODE_ALL, 400);
        run_test("control_flags", MODE_CTRL, 400);
        run_test("illegal_opcodes", MODE_ILLEGAL, 300);
        run_test("random_mix", MODE_MIX, 500);

        $display("tests=%0d checks=%0d errors=%0d", n_tests, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* verif/rv32i_decoder_sva.sv */
module rv32i_decoder_sva import rv32i_pkg::*; #(
    parameter int XLEN = XLEN_DEFAULT
) (
    input logic            clk_i,
    input logic            arst_n_i,
    input logic            req_i,
    input logic            ack_o,
    input hs_state_t       state_q,
    input logic            ins_err_o,
    input zone_t           zone_o,
    input alu_op_t         aluop_o,
    input logic [XLEN-1:0] imm_o
);

    // req may drop one edge before ack falls
    a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ack_o |-> (req_i || $past(req_i)))
        else $error("ack high without a pending request");

    // capture edge, then result edge
    a_ack_latency: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (state_q == IDLE && req_i) |=> !ack_o ##1 ack_o)
        else $error("ack did not rise two edges after the request");

    a_ack_release: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        (ack_o && !req_i) |=> !ack_o)
        else $error("ack still high after the request dropped");

    a_out_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        ack_o |=> $stable({ins_err_o, zone_o, aluop_o, imm_o}))
        else $error("decode outputs changed while ack was high");

endmodule

bind dec_handshake rv32i_decoder_sva #(.XLEN(XLEN)) u_sva (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .req_i     (req_i),
    .ack_o     (ack_o),
    .state_q   (state_q),
    .ins_err_o (ins_err_o),
    .zone_o    (zone_o),
    .aluop_o   (aluop_o),
    .imm_o     (imm_o)
);

/* logic/rv32i_decoder.sv */
module rv32i_decoder import rv32i_pkg::*; #(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            req_i,
    input  ins_t            ins_i,
    output logic            ack_o,
    output logic            ins_err_o,
    output logic            jump_o,
    output zone_t           zone_o,
    output logic            regd_tgt_o,
    output reg_addr_t       regd_addr_o,
    output logic            regs1_rd_o,
    output reg_addr_t       regs1_addr_o,
    output logic            regs2_rd_o,
    output reg_addr_t       regs2_addr_o,
    output logic [XLEN-1:0] imm_o,
    output logic            link_o,
    output logic            sels1_pc_o,
    output logic            sels2_imm_o,
    output logic            selcmps2_imm_o,
    output alu_op_t         aluop_o,
    output funct3_t         funct3_o,
    output logic            conditional_o
);

    ins_fields_if                 u_fields_if ();
    dec_result_if #(.XLEN(XLEN))  u_res_if ();

    dec_handshake #(.XLEN(XLEN)) u_handshake (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .req_i          (req_i),
        .ins_i          (ins_i),
        .ack_o          (ack_o),
        .ins_err_o      (ins_err_o),
        .jump_o         (jump_o),
        .zone_o         (zone_o),
        .regd_tgt_o     (regd_tgt_o),
        .regd_addr_o    (regd_addr_o),
        .regs1_rd_o     (regs1_rd_o),
        .regs1_addr_o   (regs1_addr_o),
        .regs2_rd_o     (regs2_rd_o),
        .regs2_addr_o   (regs2_addr_o),
        .imm_o          (imm_o),
        .link_o         (link_o),
        .sels1_pc_o     (sels1_pc_o),
        .sels2_imm_o    (sels2_imm_o),
        .selcmps2_imm_o (selcmps2_imm_o),
        .aluop_o        (aluop_o),
        .funct3_o       (funct3_o),
        .conditional_o  (conditional_o),
        .fields         (u_fields_if.src),
        .res            (u_res_if.sink)
    );

    major_decoder u_major_decoder (
        .fields (u_fields_if.cls),
        .res    (u_res_if.ctl)
    );

    alu_op_decoder u_alu_op_decoder (
        .fields (u_fields_if.user),
        .res    (u_res_if.alu)
    );

    imm_gen #(.XLEN(XLEN)) u_imm_gen (
        .fields (u_fields_if.user),
        .res    (u_res_if.immg)
    );

endmodule

/* logic/dec_handshake.sv */
module dec_handshake import rv32i_pkg::*; #(
    parameter int XLEN = XLEN_DEFAULT
) (
    input  logic            clk_i,
    input  logic            arst_n_i,
    input  logic            req_i,
    input  ins_t            ins_i,
    output logic            ack_o,
    output logic            ins_err_o,
    output logic            jump_o,
    output zone_t           zone_o,
    output logic            regd_tgt_o,
    output reg_addr_t       regd_addr_o,
    output logic            regs1_rd_o,
    output reg_addr_t       regs1_addr_o,
    output logic            regs2_rd_o,
    output reg_addr_t       regs2_addr_o,
    output logic [XLEN-1:0] imm_o,
    output logic            link_o,
    output logic            sels1_pc_o,
    output logic            sels2_imm_o,
    output logic            selcmps2_imm_o,
    output alu_op_t         aluop_o,
    output funct3_t         funct3_o,
    output logic            conditional_o,
    ins_fields_if.src       fields,
    dec_result_if.sink      res
);

    hs_state_t state_q;
    ins_t      ins_q;

    // -------------------------------------------------------------------------
    // four-phase handshake
    // -------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req_i) begin
                        state_q <= DECODE;
                    end
                end
                DECODE: begin
                    state_q <= ACK; // results registered here
                end
                ACK: begin
                    if (!req_i) begin
                        state_q <= IDLE;
                    end
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    assign ack_o = (state_q == ACK);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ins_q <= '0;
        end else if (state_q == IDLE && req_i) begin
            ins_q <= ins_i; // new request
        end
    end

    // -------------------------------------------------------------------------
    // field split
    // -------------------------------------------------------------------------
    assign fields.ins    = ins_q;
    assign fields.opcode = ins_q[6:0];
    assign fields.rd     = ins_q[11:7];
    assign fields.funct3 = ins_q[14:12];
    assign fields.rs1    = ins_q[19:15];
    assign fields.rs2    = ins_q[24:20];
    assign fields.funct7 = ins_q[31:25];

    assign regd_addr_o  = fields.rd;
    assign regs1_addr_o = fields.rs1;
    assign regs2_addr_o = fields.rs2;
    assign funct3_o     = fields.funct3;

    // -------------------------------------------------------------------------
    // result register
    // -------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ins_err_o      <= 1'b0;
            jump_o         <= 1'b0;
            zone_o         <= NONE;
            regd_tgt_o     <= 1'b0;
            regs1_rd_o     <= 1'b0;
            regs2_rd_o     <= 1'b0;
            imm_o          <= '0;
            link_o         <= 1'b0;
            sels1_pc_o     <= 1'b0;
            sels2_imm_o    <= 1'b0;
            selcmps2_imm_o <= 1'b0;
            aluop_o        <= ADD;
            conditional_o  <= 1'b0;
        end else if (state_q == DECODE) begin
            ins_err_o      <= res.maj_err | res.alu_err;
            jump_o         <= res.jump;
            zone_o         <= res.zone;
            regd_tgt_o     <= res.regd_tgt;
            regs1_rd_o     <= res.regs1_rd;
            regs2_rd_o     <= res.regs2_rd;
            imm_o          <= res.imm;
            link_o         <= res.link;
            sels1_pc_o     <= res.sels1_pc;
            sels2_imm_o    <= res.sels2_imm;
            selcmps2_imm_o <= res.selcmps2_imm;
            aluop_o        <= res.aluop;
            conditional_o  <= res.conditional;
        end
    end

endmodule

/* logic/major_decoder.sv */
module major_decoder import rv32i_pkg::*; (
    ins_fields_if.cls fields,
    dec_result_if.ctl res
);

    always_comb begin
        fields.ins_class = CLS_ILLEGAL;
        res.maj_err      = 1'b0;
        res.jump         = 1'b0;
        res.zone         = NONE;
        res.regd_tgt     = 1'b0;
        res.regs1_rd     = 1'b0;
        res.regs2_rd     = 1'b0;
        res.link         = 1'b0;
        res.sels1_pc     = 1'b0;
        res.sels2_imm    = 1'b0;
        res.conditional  = 1'b0;

        case (fields.opcode)
            OPC_LUI: begin
                fields.ins_class = CLS_LUI;
                res.zone         = REGFILE;
                res.regd_tgt     = 1'b1;
                res.sels2_imm    = 1'b1;
            end
            OPC_AUIPC: begin
                fields.ins_class = CLS_AUIPC;
                res.zone         = REGFILE;
                res.regd_tgt     = 1'b1;
                res.sels1_pc     = 1'b1; // pc + imm
                res.sels2_imm    = 1'b1;
            end
            OPC_JAL: begin
                fields.ins_class = CLS_JAL;
                res.jump         = 1'b1;
                res.zone         = REGFILE;
                res.regd_tgt     = 1'b1;
                res.link         = 1'b1;
                res.sels1_pc     = 1'b1;
                res.sels2_imm    = 1'b1;
            end
            OPC_JALR: begin
                fields.ins_class = CLS_JALR;
                res.jump         = 1'b1;
                res.zone         = REGFILE;
                res.regd_tgt     = 1'b1;
                res.regs1_rd     = 1'b1;
                res.link         = 1'b1;
                res.sels2_imm    = 1'b1;
                res.maj_err      = (fields.funct3 != 3'd0);
            end
            OPC_BRANCH: begin
                fields.ins_class = CLS_BRANCH;
                res.jump         = 1'b1;
                res.regs1_rd     = 1'b1;
                res.regs2_rd     = 1'b1;
                res.sels1_pc     = 1'b1; // target from pc
                res.sels2_imm    = 1'b1;
                res.conditional  = 1'b1;
                res.maj_err      = !(fields.funct3 inside {3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7});
            end
            OPC_LOAD: begin
                fields.ins_class = CLS_LOAD;
                res.zone         = LOADQ;
                res.regd_tgt     = 1'b1;
                res.regs1_rd     = 1'b1;
                res.sels2_imm    = 1'b1;
                res.maj_err      = !(fields.funct3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
            end
            OPC_STORE: begin
                fields.ins_class = CLS_STORE;
                res.zone         = STOREQ;
                res.regs1_rd     = 1'b1;
                res.regs2_rd     = 1'b1;
                res.sels2_imm    = 1'b1;
                res.maj_err      = !(fields.funct3 inside {3'd0, 3'd1, 3'd2});
            end
            OPC_OPIMM: begin
                fields.ins_class = CLS_OPIMM;
                res.zone         = REGFILE;
                res.regd_tgt     = 1'b1;
                res.regs1_rd     = 1'b1;
                res.sels2_imm    = 1'b1;
            end
            OPC_OP: begin
                fields.ins_class = CLS_OP;
                res.zone         = REGFILE;
                res.regd_tgt     = 1'b1;
                res.regs1_rd     = 1'b1;
                res.regs2_rd     = 1'b1;
            end
            default: begin
                res.maj_err = 1'b1; // system, misc-mem and unknown
            end
        endcase
    end

endmodule

/* logic/alu_op_decoder.sv */
module alu_op_decoder import rv32i_pkg::*; (
    ins_fields_if.user fields,
    dec_result_if.alu  res
);

    logic is_op;
    logic is_opimm;
    logic f7_base;
    logic f7_alt;

    assign is_op    = (fields.ins_class == CLS_OP);
    assign is_opimm = (fields.ins_class == CLS_OPIMM);
    assign f7_base  = (fields.funct7 == FUNCT7_BASE);
    assign f7_alt   = (fields.funct7 == FUNCT7_ALT);

    always_comb begin
        res.aluop        = ADD;
        res.selcmps2_imm = 1'b0;
        res.alu_err      = 1'b0;

        if (fields.ins_class == CLS_LUI) begin
            res.aluop = MOV;
        end else if (is_op || is_opimm) begin
            case (fields.funct3)
                F3_ADDSUB: begin
                    if (is_op && f7_alt) begin
                        res.aluop = SUB; // no subi
                    end
                    res.alu_err = is_op && !f7_base && !f7_alt;
                end
                F3_SLL: begin
                    res.aluop   = SLL;
                    res.alu_err = !f7_base;
                end
                F3_SLT, F3_SLTU: begin
                    res.aluop        = (fields.funct3 == F3_SLT) ? SLT : SLTU;
                    res.selcmps2_imm = is_opimm;
                    res.alu_err      = is_op && !f7_base;
                end
                F3_SRLSRA: begin
                    if (f7_base) begin
                        res.aluop = SRL;
                    end else if (f7_alt) begin
                        res.aluop = SRA;
                    end else begin
                        res.alu_err = 1'b1;
                    end
                end
                F3_XOR: begin
                    res.aluop   = XOR;
                    res.alu_err = is_op && !f7_base;
                end
                F3_OR: begin
                    res.aluop   = OR;
                    res.alu_err = is_op && !f7_base;
                end
                default: begin
                    res.aluop   = AND;
                    res.alu_err = is_op && !f7_base;
                end
            endcase
        end
    end

endmodule

/* logic/imm_gen.sv */
module imm_gen import rv32i_pkg::*; #(
    parameter int XLEN = XLEN_DEFAULT
) (
    ins_fields_if.user fields,
    dec_result_if.immg res
);

    logic [XLEN-1:0] sign_ext;

    assign sign_ext = {XLEN{fields.ins[31]}};

    always_comb begin
        case (fields.ins_class)
            CLS_JALR, CLS_LOAD, CLS_OPIMM: begin // i-type
                res.imm = {sign_ext[XLEN-1:11], fields.ins[30:20]};
            end
            CLS_STORE: begin
                res.imm = {sign_ext[XLEN-1:11], fields.ins[30:25], fields.ins[11:7]};
            end
            CLS_BRANCH: begin
                res.imm = {sign_ext[XLEN-1:12], fields.ins[7], fields.ins[30:25],
                           fields.ins[11:8], 1'b0};
            end
            CLS_LUI, CLS_AUIPC: begin
                res.imm = {sign_ext[XLEN-1:31], fields.ins[30:12], 12'b0};
            end
            CLS_JAL: begin
                res.imm = {sign_ext[XLEN-1:20], fields.ins[19:12], fields.ins[20],
                           fields.ins[30:21], 1'b0};
            end
            default: begin
                res.imm = '0; // r-type and illegal
            end
        endcase
    end

endmodule

/* logic/rv32i_dec_if.sv */
interface ins_fields_if import rv32i_pkg::*; ();

    ins_t       ins;
    opcode_t    opcode;
    funct3_t    funct3;
    funct7_t    funct7;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    ins_class_t ins_class;

    modport src  (output ins, opcode, funct3, funct7, rd, rs1, rs2);
    modport cls  (input opcode, funct3, output ins_class);
    modport user (input ins, opcode, funct3, funct7, rd, rs1, rs2, ins_class);

endinterface

interface dec_result_if import rv32i_pkg::*; #(
    parameter int XLEN = XLEN_DEFAULT
) ();

    logic            maj_err;
    logic            alu_err;
    logic            jump;
    zone_t           zone;
    logic            regd_tgt;
    logic            regs1_rd;
    logic            regs2_rd;
    logic            link;
    logic            sels1_pc;
    logic            sels2_imm;
    logic            selcmps2_imm;
    logic            conditional;
    alu_op_t         aluop;
    logic [XLEN-1:0] imm;

    modport ctl  (output maj_err, jump, zone, regd_tgt, regs1_rd, regs2_rd, link,
                  sels1_pc, sels2_imm, conditional);
    modport alu  (output aluop, selcmps2_imm, alu_err);
    modport immg (output imm);
    modport sink (input maj_err, alu_err, jump, zone, regd_tgt, regs1_rd, regs2_rd,
                  link, sels1_pc, sels2_imm, selcmps2_imm, conditional, aluop, imm);

endinterface

/* logic/rv32i_pkg.sv */
package rv32i_pkg;

    localparam int XLEN_DEFAULT = 32;

    typedef logic [31:0] ins_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;
    typedef logic [4:0]  reg_addr_t;

    // -------------------------------------------------------------------------
    // major opcodes
    // -------------------------------------------------------------------------
    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OPIMM  = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;

    // minor opcodes of OP and OP-IMM
    localparam funct3_t F3_ADDSUB = 3'd0;
    localparam funct3_t F3_SLL    = 3'd1;
    localparam funct3_t F3_SLT    = 3'd2;
    localparam funct3_t F3_SLTU   = 3'd3;
    localparam funct3_t F3_XOR    = 3'd4;
    localparam funct3_t F3_SRLSRA = 3'd5;
    localparam funct3_t F3_OR     = 3'd6;
    localparam funct3_t F3_AND    = 3'd7;

    localparam funct7_t FUNCT7_BASE = 7'b0000000;
    localparam funct7_t FUNCT7_ALT  = 7'b0100000; // sub / sra

    typedef enum logic [3:0] {
        CLS_LUI, CLS_AUIPC, CLS_JAL, CLS_JALR, CLS_BRANCH,
        CLS_LOAD, CLS_STORE, CLS_OPIMM, CLS_OP, CLS_ILLEGAL
    } ins_class_t;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, MOV
    } alu_op_t;

    typedef enum logic [1:0] {NONE, REGFILE, LOADQ, STOREQ} zone_t;

    typedef enum logic [1:0] {IDLE, DECODE, ACK} hs_state_t;

endpackage
